/* include/dadda_defines.svh */
`ifndef DADDA_DEFINES_SVH
`define DADDA_DEFINES_SVH

// operand width, product is twice this
`define DADDA_WIDTH 16

// reduction stages for 16 -> 2
`define DADDA_STAGES 6

// bits per lookahead group in the final adder
`define CLA_GROUP 4

`endif

/* hdl/mult_types_pkg.sv */
`include "dadda_defines.svh"

package mult_types_pkg;

    typedef logic [`DADDA_WIDTH-1:0] operand_t;

    typedef logic [2*`DADDA_WIDTH-1:0] product_t;

    // operand pair entering the multiplier
    typedef struct packed {
        operand_t a;
        operand_t b;
    } mult_req_t;

    typedef struct packed {
        product_t product;
    } mult_rsp_t;

endpackage

/* hdl/dadda_tree_pkg.sv */
`include "dadda_defines.svh"

package dadda_tree_pkg;

    localparam int HEAP_COLS = 2 * `DADDA_WIDTH;
    localparam int HEAP_ROWS = `DADDA_WIDTH;

    // one column per product bit, occupied bits packed at the bottom
    typedef logic [HEAP_COLS-1:0][HEAP_ROWS-1:0] bit_heap_t;

    // column height left after each stage
    localparam int STAGE_TARGET [`DADDA_STAGES] = '{13, 9, 6, 4, 3, 2};

    function automatic int pp_height(input int col);
        return (col < HEAP_ROWS) ? col + 1 : HEAP_COLS - 1 - col;
    endfunction

    // height of a column entering a stage
    function automatic int col_height(input int stage, input int col);
        int h [HEAP_COLS];
        int cin;
        int e;
        for (int c = 0; c < HEAP_COLS; c++) begin
            h[c] = pp_height(c);
        end
        for (int s = 0; s < stage; s++) begin
            cin = 0;
            for (int c = 0; c < HEAP_COLS; c++) begin
                e = h[c] + cin - STAGE_TARGET[s];
                if (e < 0) begin
                    e = 0;
                end
                h[c] = h[c] + cin - e;
                cin = (e + 1) / 2;
            end
        end
        return h[col];
    endfunction

    // bits to remove from a column, counting carries from below
    function automatic int col_excess(input int stage, input int col);
        int cin;
        int e;
        cin = 0;
        e = 0;
        for (int c = 0; c <= col; c++) begin
            e = col_height(stage, c) + cin - STAGE_TARGET[stage];
            if (e < 0) begin
                e = 0;
            end
            cin = (e + 1) / 2;
        end
        return e;
    endfunction

    function automatic int carry_in(input int stage, input int col);
        return (col == 0) ? 0 : (col_excess(stage, col - 1) + 1) / 2;
    endfunction

endpackage

/* hdl/partial_products.sv */
`timescale 1ns/100ps
`include "dadda_defines.svh"

module partial_products (
    input  mult_types_pkg::operand_t  a,
    input  mult_types_pkg::operand_t  b,
    output dadda_tree_pkg::bit_heap_t heap
);

    // bit a[i]&b[j] lands in column i+j
    // lower half fills by i, upper half by distance from the top row
    always_comb begin
        heap = '0;
        for (int i = 0; i < `DADDA_WIDTH; i++) begin
            for (int j = 0; j < `DADDA_WIDTH; j++) begin
                heap[i + j][(i + j < `DADDA_WIDTH) ? i : `DADDA_WIDTH - 1 - j] = a[i] & b[j];
            end
        end
    end

endmodule

/* hdl/dadda_stage.sv */
`timescale 1ns/100ps

module dadda_stage #(
    parameter int STAGE = 0
) (
    input  dadda_tree_pkg::bit_heap_t heap_in,
    output dadda_tree_pkg::bit_heap_t heap_out
);

    localparam int COLS = dadda_tree_pkg::HEAP_COLS;
    localparam int ROWS = dadda_tree_pkg::HEAP_ROWS;

    // carry[c] holds the carries arriving at column c
    logic [COLS-1:0][ROWS-1:0] carry;

    assign carry[0] = '0;

    for (genvar c = 0; c < COLS; c++) begin : g_col
        localparam int H_IN   = dadda_tree_pkg::col_height(STAGE, c);
        localparam int EXCESS = dadda_tree_pkg::col_excess(STAGE, c);
        localparam int N_FA   = EXCESS / 2;
        localparam int N_HA   = EXCESS % 2;
        localparam int N_RED  = N_FA + N_HA;
        localparam int USED   = 3 * N_FA + 2 * N_HA;
        localparam int N_PASS = H_IN - USED;
        localparam int CIN    = dadda_tree_pkg::carry_in(STAGE, c);

        logic [ROWS-1:0] col_out;

        // sums first, then untouched bits, then carries from below
        always_comb begin
            col_out = '0;
            for (int k = 0; k < N_FA; k++) begin
                col_out[k] = heap_in[c][3*k] ^ heap_in[c][3*k+1] ^ heap_in[c][3*k+2];
            end
            for (int k = 0; k < N_HA; k++) begin
                col_out[N_FA + k] = heap_in[c][3*N_FA] ^ heap_in[c][3*N_FA+1];
            end
            for (int k = 0; k < N_PASS; k++) begin
                col_out[N_RED + k] = heap_in[c][USED + k];
            end
            for (int k = 0; k < CIN; k++) begin
                col_out[N_RED + N_PASS + k] = carry[c][k];
            end
        end

        assign heap_out[c] = col_out;

        // top column never carries, the product fits
        if (c < COLS - 1) begin : g_cout
            logic [ROWS-1:0] col_cout;

            always_comb begin
                col_cout = '0;
                for (int k = 0; k < N_FA; k++) begin
                    col_cout[k] = (heap_in[c][3*k] & heap_in[c][3*k+1])
                                | (heap_in[c][3*k+1] & heap_in[c][3*k+2])
                                | (heap_in[c][3*k+2] & heap_in[c][3*k]);
                end
                for (int k = 0; k < N_HA; k++) begin
                    col_cout[N_FA + k] = heap_in[c][3*N_FA] & heap_in[c][3*N_FA+1];
                end
            end

            assign carry[c+1] = col_cout;
        end
    end

endmodule

/* hdl/dadda_tree.sv */
`timescale 1ns/100ps
`include "dadda_defines.svh"

module dadda_tree (
    input  dadda_tree_pkg::bit_heap_t heap,
    output mult_types_pkg::product_t  row_sum,
    output mult_types_pkg::product_t  row_carry
);

    // heap between stages, index 0 is the raw AND array
    dadda_tree_pkg::bit_heap_t stage_heap [`DADDA_STAGES+1];

    assign stage_heap[0] = heap;

    // 16 -> 13 -> 9 -> 6 -> 4 -> 3 -> 2
    for (genvar s = 0; s < `DADDA_STAGES; s++) begin : g_stage
        dadda_stage #(
            .STAGE (s)
        ) u_stage (
            .heap_in  (stage_heap[s]),
            .heap_out (stage_heap[s+1])
        );
    end

    // at most two bits left per column
    always_comb begin
        for (int c = 0; c < dadda_tree_pkg::HEAP_COLS; c++) begin
            row_sum[c]   = stage_heap[`DADDA_STAGES][c][0];
            row_carry[c] = stage_heap[`DADDA_STAGES][c][1];
        end
    end

endmodule

/* hdl/cla_adder.sv */
`timescale 1ns/100ps
`include "dadda_defines.svh"

module cla_adder (
    input  mult_types_pkg::product_t x,
    input  mult_types_pkg::product_t y,
    output mult_types_pkg::product_t sum,
    output logic                     cout
);

    localparam int W    = 2 * `DADDA_WIDTH;
    localparam int G    = `CLA_GROUP;
    localparam int NGRP = W / G;

    logic [W-1:0]    g;
    logic [W-1:0]    p;
    logic [W-1:0]    c;
    logic [NGRP-1:0] grp_g;
    logic [NGRP-1:0] grp_p;
    logic [NGRP:0]   grp_c;

    // flat carry into position n from generate/propagate and cin
    function automatic logic look_carry(input logic [NGRP-1:0] gen, input logic [NGRP-1:0] prop,
                                        input logic cin, input int n);
        logic cy;
        logic term;
        cy = cin;
        for (int k = 0; k < n; k++) begin
            cy = cy & prop[k];
        end
        for (int m = 0; m < n; m++) begin
            term = gen[m];
            for (int k = m + 1; k < n; k++) begin
                term = term & prop[k];
            end
            cy = cy | term;
        end
        return cy;
    endfunction

    assign g = x & y;
    assign p = x ^ y;

    always_comb begin
        for (int k = 0; k < NGRP; k++) begin
            grp_g[k] = look_carry(NGRP'(g[k*G +: G]), NGRP'(p[k*G +: G]), 1'b0, G);
            grp_p[k] = &p[k*G +: G];
        end
    end

    // second level, group carries
    always_comb begin
        grp_c[0] = 1'b0;
        for (int k = 0; k < NGRP; k++) begin
            grp_c[k+1] = look_carry(grp_g, grp_p, grp_c[0], k + 1);
        end
    end

    always_comb begin
        for (int k = 0; k < NGRP; k++) begin
            for (int j = 0; j < G; j++) begin
                c[k*G + j] = look_carry(NGRP'(g[k*G +: G]), NGRP'(p[k*G +: G]), grp_c[k], j);
            end
        end
    end

    assign sum  = p ^ c;
    assign cout = grp_c[NGRP];

endmodule

/* hdl/dadda_mult.sv */
`timescale 1ns/100ps

module dadda_mult (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  mult_types_pkg::mult_req_t req,
    output logic                      out_valid,
    output mult_types_pkg::mult_rsp_t rsp
);

    mult_types_pkg::mult_req_t req_q;
    logic                      stage_valid;
    dadda_tree_pkg::bit_heap_t heap;
    mult_types_pkg::product_t  row_sum;
    mult_types_pkg::product_t  row_carry;
    mult_types_pkg::product_t  product;
    logic                      carry_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            stage_valid <= in_valid;
            out_valid   <= stage_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            req_q <= req;
        end
    end

    partial_products u_pp (
        .a    (req_q.a),
        .b    (req_q.b),
        .heap (heap)
    );

    dadda_tree u_tree (
        .heap      (heap),
        .row_sum   (row_sum),
        .row_carry (row_carry)
    );

    cla_adder u_cla (
        .x    (row_sum),
        .y    (row_carry),
        .sum  (product),
        .cout (carry_out)
    );

    // rsp holds while no result is due
    always_ff @(posedge clk) begin
        if (stage_valid) begin
            rsp.product <= product;
        end
    end

    a_idle_after_rst: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    a_latency: assert property (@(posedge clk)
        !$past(rst) && !$past(rst, 2) |-> out_valid == $past(in_valid, 2))
        else $error("out_valid is not in_valid delayed by two cycles");

    // tree plus adder must fit 32 bits
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) stage_valid |-> !carry_out)
        else $error("final adder carried out of the product");

endmodule

/* tb/tb_dadda_mult.sv */
`timescale 1ns/100ps
`include "dadda_defines.svh"

module tb_dadda_mult;

    localparam int RESULT_TIMEOUT = 10;
    localparam int DRAIN_TIMEOUT  = 20;

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    mult_types_pkg::mult_req_t req;
    logic                      out_valid;
    mult_types_pkg::mult_rsp_t rsp;

    mult_types_pkg::product_t exp_q [$];
    mult_types_pkg::product_t exp_head = '0;
    logic [1:0]               vld_hist = 2'b00;
    logic                     started  = 1'b0;
    int                       val_errs = 0;
    int                       vld_errs = 0;
    int                       timeout_errs = 0;
    int                       returned = 0;
    int                       expected_returns = 0;

    dadda_mult u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reference model, sees the values from before the edge
    always @(posedge clk) begin
        started <= 1'b1;
        if (rst) begin
            exp_q.delete();
            vld_hist <= 2'b00;
        end else begin
            if (out_valid) begin
                returned++;
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end
            end
            if (in_valid) begin
                exp_q.push_back(mult_types_pkg::product_t'(req.a)
                                * mult_types_pkg::product_t'(req.b));
            end
            vld_hist <= {vld_hist[0], in_valid};
        end
        exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    a_valid_delay: assert property (@(posedge clk)
        started |-> out_valid == vld_hist[1])
        else begin
            vld_errs++;
            $display("CHECK FAILED @ %0t: out_valid %b, expected %b",
                     $time, $sampled(out_valid), $sampled(vld_hist[1]));
        end

    a_product: assert property (@(posedge clk)
        started && out_valid |-> rsp.product == exp_head)
        else begin
            val_errs++;
            $display("CHECK FAILED @ %0t: product %h, expected %h",
                     $time, $sampled(rsp.product), $sampled(exp_head));
        end

    task automatic send_pair(input mult_types_pkg::operand_t a,
                             input mult_types_pkg::operand_t b);
        @(posedge clk);
        in_valid <= 1'b1;
        req.a    <= a;
        req.b    <= b;
        expected_returns++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        while (!out_valid && cycles < RESULT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!out_valid) begin
            timeout_errs++;
            $display("timeout: the first result never appeared on out_valid");
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (exp_q.size() > 0 && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() > 0) begin
            timeout_errs++;
            $display("timeout: %0d results still outstanding", exp_q.size());
        end
    endtask

    initial begin
        void'($urandom(18));
        rst      <= 1'b1;
        in_valid <= 1'b0;
        req      <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // quiet period, then a single pair
        idle_cycles(4);
        send_pair(16'd3, 16'd5);
        idle_cycles(1);
        wait_result();
        wait_drain();

        // corner operands
        send_pair(16'h0000, 16'h0000);
        send_pair(16'h0001, 16'h1234);
        send_pair(16'hbeef, 16'h0001);
        send_pair(16'hffff, 16'hffff);
        send_pair(16'haaaa, 16'h5555);
        send_pair(16'h5555, 16'h5555);
        send_pair(16'haaaa, 16'haaaa);
        for (int i = 0; i < `DADDA_WIDTH; i++) begin
            send_pair(16'h0001 << i, 16'h8000 >> i);
            send_pair(16'h0001 << i, 16'hffff);
        end
        idle_cycles(1);
        wait_drain();

        // back to back random pairs
        for (int i = 0; i < 300; i++) begin
            send_pair(16'($urandom), 16'($urandom));
        end
        idle_cycles(1);
        wait_drain();

        // random gaps in in_valid
        for (int i = 0; i < 200; i++) begin
            if ($urandom_range(2) == 0) begin
                idle_cycles(1);
            end else begin
                send_pair(16'($urandom), 16'($urandom));
            end
        end
        idle_cycles(1);
        wait_drain();

        // reset with two pairs in flight, neither comes back
        @(posedge clk);
        in_valid <= 1'b1;
        req      <= '{a: 16'h1234, b: 16'h5678};
        @(posedge clk);
        req      <= '{a: 16'h9abc, b: 16'hdef0};
        rst      <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
        rst      <= 1'b0;
        // the two cycles where the pairs would have come out
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            a_flushed: assert (!out_valid)
                else begin
                    vld_errs++;
                    $display("CHECK FAILED @ %0t: out_valid high after reset", $time);
                end
        end
        idle_cycles(2);

        // traffic after the reset pulse
        for (int i = 0; i < 10; i++) begin
            send_pair(16'($urandom), 16'($urandom));
        end
        idle_cycles(1);
        wait_drain();

        @(negedge clk);
        a_count: assert (returned == expected_returns)
            else begin
                vld_errs++;
                $display("CHECK FAILED @ %0t: %0d results returned, expected %0d",
                         $time, returned, expected_returns);
            end

        $display("errors: value %0d, valid %0d, timeout %0d",
                 val_errs, vld_errs, timeout_errs);
        if (val_errs + vld_errs + timeout_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
hdl/mult_types_pkg.sv
hdl/dadda_tree_pkg.sv
hdl/partial_products.sv
hdl/dadda_stage.sv
hdl/dadda_tree.sv
hdl/cla_adder.sv
hdl/dadda_mult.sv
tb/tb_dadda_mult.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dadda_mult
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
